// File: source/cacheTypesPkg.sv
/* cache types
   address and word widths, CPU and memory opcodes */
`default_nettype none

package cacheTypesPkg;

    localparam int addrWidth = 8;
    localparam int wordWidth = 32;  // one word per line

    typedef logic [addrWidth-1:0] addrType;
    typedef logic [wordWidth-1:0] wordType;

    typedef enum logic [1:0] {
        cpuIdle,
        cpuRead,
        cpuWrite
    } cpuOpType;

    typedef enum logic [1:0] {
        memIdle,
        memRead,
        memWrite
    } memOpType;

endpackage

`default_nettype wire

// File: source/coherencePkg.sv
/* MSI coherence types
   line states and snooping bus messages */
`default_nettype none

package coherencePkg;

    // first three are stable, the rest wait on the miss handler
    typedef enum logic [2:0] {
        invalid,
        shared,
        modified,
        snoopWriteBack,
        missBusy,
        invalidateBusy
    } lineStateType;

    typedef enum logic [1:0] {
        busNone,
        busReadMiss,
        busWriteMiss,
        busInvalidate
    } busMsgType;

endpackage

`default_nettype wire

// File: source/lineStore.sv
/* line store
   tag and data of the single line, CPU and snoop address match */
`timescale 1ns/100ps
`default_nettype none

module lineStore
    import cacheTypesPkg::*;
(
    input  wire logic    clk,
    input  wire logic    reset,
    input  wire logic    load,
    input  wire logic    writeWord,
    input  wire logic    fillFromMem,
    input  wire addrType newTag,
    input  wire wordType memData,
    input  wire wordType cpuData,
    input  wire logic    valid,
    input  wire addrType cpuAddr,
    input  wire addrType busAddr,
    output addrType      tag,
    output wordType      lineData,
    output logic         cpuHit,
    output logic         snoopHit
);

    always_ff @(posedge clk) begin
        if (reset) begin
            tag      <= '0;
            lineData <= '0;
        end else if (load) begin
            tag      <= newTag;
            lineData <= fillFromMem ? memData : cpuData;  // write miss takes cpu word
        end else if (writeWord) begin
            lineData <= cpuData;  // hit, tag unchanged
        end
    end

    assign cpuHit   = valid && (tag == cpuAddr);
    assign snoopHit = valid && (tag == busAddr);

endmodule

`default_nettype wire

// File: source/missHandler.sv
/* miss handler
   victim write-back, miss broadcast and fill, invalidate broadcast */
`timescale 1ns/100ps
`default_nettype none

module missHandler
    import cacheTypesPkg::*;
    import coherencePkg::*;
(
    input  wire logic      clk,
    input  wire logic      reset,
    input  wire logic      start,
    input  wire busMsgType msgKind,
    input  wire logic      writeBack,
    input  wire addrType   reqAddr,
    input  wire addrType   victimAddr,
    input  wire wordType   victimData,
    input  wire wordType   memReadData,
    input  wire logic      memDone,
    output memOpType       memOp,
    output addrType        memAddr,
    output wordType        memWriteData,
    output busMsgType      busMsgOut,
    output addrType        busAddrOut,
    output logic           finished,
    output wordType        fillData
);

    typedef enum logic [1:0] {
        mhIdle,
        mhWriteBack,
        mhFill,
        mhBroadcast
    } handlerStateType;

    handlerStateType handlerState;
    busMsgType       pendingKind;  // sent once write-back is done

    always_ff @(posedge clk) begin
        if (reset) begin
            handlerState <= mhIdle;
            memOp        <= memIdle;
            busMsgOut    <= busNone;
            finished     <= 1'b0;
            pendingKind  <= busNone;
        end else begin
            finished <= 1'b0;
            case (handlerState)
                mhIdle: begin
                    if (start) begin
                        pendingKind <= msgKind;
                        if (writeBack) begin
                            memOp        <= memWrite;
                            memAddr      <= victimAddr;
                            memWriteData <= victimData;
                            handlerState <= mhWriteBack;
                        end else if (msgKind == busInvalidate) begin
                            busMsgOut    <= busInvalidate;
                            busAddrOut   <= reqAddr;
                            finished     <= 1'b1;  // same cycle as the broadcast
                            handlerState <= mhBroadcast;
                        end else if (msgKind != busNone) begin
                            busMsgOut    <= msgKind;
                            busAddrOut   <= reqAddr;
                            memOp        <= memRead;
                            memAddr      <= reqAddr;
                            handlerState <= mhFill;
                        end else begin
                            finished <= 1'b1;  // nothing to do
                        end
                    end
                end
                mhWriteBack: begin
                    if (memDone) begin
                        if (pendingKind == busNone) begin
                            // snoop write-back ends here
                            memOp        <= memIdle;
                            finished     <= 1'b1;
                            handlerState <= mhIdle;
                        end else begin
                            busMsgOut    <= pendingKind;
                            busAddrOut   <= reqAddr;
                            memOp        <= memRead;
                            memAddr      <= reqAddr;
                            handlerState <= mhFill;
                        end
                    end
                end
                mhFill: begin
                    if (memDone) begin
                        fillData     <= memReadData;
                        memOp        <= memIdle;
                        busMsgOut    <= busNone;
                        finished     <= 1'b1;
                        handlerState <= mhIdle;
                    end
                end
                mhBroadcast: begin
                    busMsgOut    <= busNone;  // invalidate lasts one cycle
                    handlerState <= mhIdle;
                end
                default: begin
                    handlerState <= mhIdle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/coherenceController.sv
/* MSI coherence controller
   line state FSM, CPU requests against snooped bus messages */
`timescale 1ns/100ps
`default_nettype none

module coherenceController
    import cacheTypesPkg::*;
    import coherencePkg::*;
(
    input  wire logic      clk,
    input  wire logic      reset,
    input  wire cpuOpType  cpuOp,
    input  wire logic      cpuHit,
    input  wire logic      snoopHit,
    input  wire busMsgType busMsgIn,
    input  wire logic      finished,
    output lineStateType   state,
    output logic           load,
    output logic           writeWord,
    output logic           fillFromMem,
    output logic           start,
    output busMsgType      msgKind,
    output logic           writeBack,
    output logic           cpuDone
);

    logic cpuReq;
    logic snoopAct;
    logic keepShared;  // snooped read miss leaves a shared copy

    // no new request while cpuDone is up
    assign cpuReq = (cpuOp != cpuIdle) && !cpuDone;

    // snoops that change the line, read miss in shared needs nothing
    always_comb begin
        snoopAct = 1'b0;
        if (snoopHit) begin
            case (busMsgIn)
                busReadMiss:   snoopAct = (state == modified);
                busWriteMiss:  snoopAct = 1'b1;
                busInvalidate: snoopAct = (state == shared);
                default:       snoopAct = 1'b0;
            endcase
        end
    end

    assign load        = (state == missBusy) && finished;
    assign fillFromMem = (cpuOp == cpuRead);

    // write hit in modified now, in shared once the invalidate is out
    assign writeWord = ((state == invalidateBusy) && finished)
                     || ((state == modified) && !snoopAct && cpuReq
                         && (cpuOp == cpuWrite) && cpuHit);

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= invalid;
            start      <= 1'b0;
            msgKind    <= busNone;
            writeBack  <= 1'b0;
            cpuDone    <= 1'b0;
            keepShared <= 1'b0;
        end else begin
            start   <= 1'b0;
            cpuDone <= 1'b0;
            case (state)
                invalid, shared, modified: begin
                    if (snoopAct) begin
                        if (state == modified) begin
                            // peer wants the dirty line
                            start      <= 1'b1;
                            msgKind    <= busNone;
                            writeBack  <= 1'b1;
                            keepShared <= (busMsgIn == busReadMiss);
                            state      <= snoopWriteBack;
                        end else begin
                            state <= invalid;
                        end
                    end else if (cpuReq) begin
                        if (cpuHit && ((cpuOp == cpuRead) || (state == modified))) begin
                            cpuDone <= 1'b1;
                        end else if (cpuHit) begin
                            start     <= 1'b1;  // write hit in shared
                            msgKind   <= busInvalidate;
                            writeBack <= 1'b0;
                            state     <= invalidateBusy;
                        end else begin
                            start     <= 1'b1;
                            msgKind   <= (cpuOp == cpuRead) ? busReadMiss : busWriteMiss;
                            writeBack <= (state == modified);  // dirty victim
                            state     <= missBusy;
                        end
                    end
                end
                snoopWriteBack: begin
                    if (finished) begin
                        state <= keepShared ? shared : invalid;
                    end
                end
                missBusy: begin
                    if (finished) begin
                        cpuDone <= 1'b1;
                        state   <= (cpuOp == cpuWrite) ? modified : shared;
                    end
                end
                invalidateBusy: begin
                    if (finished) begin
                        cpuDone <= 1'b1;
                        state   <= modified;
                    end
                end
                default: begin
                    state <= invalid;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/msiCacheTop.sv
/* MSI snooping cache, single line
   controller, line store and miss handler */
`timescale 1ns/100ps
`default_nettype none

module msiCacheTop
    import cacheTypesPkg::*;
    import coherencePkg::*;
(
    input  wire logic      clk,
    input  wire logic      reset,
    input  wire cpuOpType  cpuOp,
    input  wire addrType   cpuAddr,
    input  wire wordType   cpuWriteData,
    output logic           cpuDone,
    output wordType        cpuReadData,
    output memOpType       memOp,
    output addrType        memAddr,
    output wordType        memWriteData,
    input  wire wordType   memReadData,
    input  wire logic      memDone,
    output busMsgType      busMsgOut,
    output addrType        busAddrOut,
    input  wire busMsgType busMsgIn,
    input  wire addrType   busAddrIn
);

    lineStateType state;
    logic         lineValid;
    logic         load;
    logic         writeWord;
    logic         fillFromMem;
    logic         start;
    logic         writeBack;
    logic         finished;
    logic         cpuHit;
    logic         snoopHit;
    busMsgType    msgKind;
    addrType      tag;
    wordType      lineData;
    wordType      fillData;

    assign lineValid   = (state == shared) || (state == modified);
    assign cpuReadData = lineData;

    coherenceController controller (
        .clk(clk), .reset(reset), .cpuOp(cpuOp), .cpuHit(cpuHit), .snoopHit(snoopHit),
        .busMsgIn(busMsgIn), .finished(finished), .state(state), .load(load),
        .writeWord(writeWord), .fillFromMem(fillFromMem), .start(start),
        .msgKind(msgKind), .writeBack(writeBack), .cpuDone(cpuDone)
    );

    lineStore store (
        .clk(clk), .reset(reset), .load(load), .writeWord(writeWord),
        .fillFromMem(fillFromMem), .newTag(cpuAddr), .memData(fillData),
        .cpuData(cpuWriteData), .valid(lineValid), .cpuAddr(cpuAddr), .busAddr(busAddrIn),
        .tag(tag), .lineData(lineData), .cpuHit(cpuHit), .snoopHit(snoopHit)
    );

    missHandler handler (
        .clk(clk), .reset(reset), .start(start), .msgKind(msgKind), .writeBack(writeBack),
        .reqAddr(cpuAddr), .victimAddr(tag), .victimData(lineData),
        .memReadData(memReadData), .memDone(memDone), .memOp(memOp), .memAddr(memAddr),
        .memWriteData(memWriteData), .busMsgOut(busMsgOut), .busAddrOut(busAddrOut),
        .finished(finished), .fillData(fillData)
    );

endmodule

`default_nettype wire

// File: tests/msiCacheProperties.sv
/* MSI cache assertions
   pulse widths of cpuDone and start, memory request held until memDone */
`timescale 1ns/100ps
`default_nettype none

module msiCacheProperties
    import cacheTypesPkg::*;
(
    input wire logic     clk,
    input wire logic     reset,
    input wire logic     cpuDone,
    input wire logic     start,
    input wire memOpType memOp,
    input wire logic     memDone
);

    int assertFails = 0;  // summed into the closing count

    cpuDoneIsPulse: assert property (@(posedge clk) disable iff (reset) cpuDone |=> !cpuDone)
        else begin
            assertFails++;
            $error("cpuDone stayed high for two cycles");
        end

    startIsPulse: assert property (@(posedge clk) disable iff (reset) start |=> !start)
        else begin
            assertFails++;
            $error("start to the miss handler lasted more than one cycle");
        end

    // request may only change on the memDone edge
    memOpHeld: assert property (@(posedge clk) disable iff (reset)
        (memOp != memIdle) && !memDone |=> $stable(memOp))
        else begin
            assertFails++;
            $error("memOp changed before memDone");
        end

endmodule

bind msiCacheTop msiCacheProperties props (
    .clk(clk), .reset(reset), .cpuDone(cpuDone), .start(start),
    .memOp(memOp), .memDone(memDone)
);

`default_nettype wire

// File: tests/msiCacheTb.sv
/* MSI cache testbench
   memory model with random latency, CPU and snoop steps from the golden file */
`timescale 1ns/100ps
`default_nettype none

module msiCacheTb
    import cacheTypesPkg::*;
    import coherencePkg::*;
();

    localparam int maxSteps = 32;
    localparam int stepFields = 8;
    localparam logic [31:0] memSalt = 32'hA5C30F00;

    logic        clk;
    logic        reset;
    cpuOpType    cpuOp;
    addrType     cpuAddr;
    wordType     cpuWriteData;
    logic        cpuDone;
    wordType     cpuReadData;
    memOpType    memOp;
    addrType     memAddr;
    wordType     memWriteData;
    wordType     memReadData;
    logic        memDone;
    busMsgType   busMsgOut;
    addrType     busAddrOut;
    busMsgType   busMsgIn;
    addrType     busAddrIn;

    wordType     memory [0:255];
    logic [31:0] golden [0:maxSteps*stepFields-1];
    int          memWait;
    int          memReads;
    int          memWrites;
    int          stepCount;
    int          errorCount = 0;
    int          checkCount = 0;
    int          cycleCount = 0;
    int          cycleLimit = 100000;
    addrType     wbAddrSeen;
    logic        writeFirst;
    busMsgType   busSeen;
    addrType     busAddrSeen;

    msiCacheTop dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        checkCount++;
        if (got !== expected) begin
            errorCount++;
            $display("Fail at %0t ns: %s got %h expected %h", $time, name, got, expected);
        end
    endtask

    task automatic clearStepRecord();
        memReads   = 0;
        memWrites  = 0;
        writeFirst = 1'b0;
        wbAddrSeen = '0;
        busSeen    = busNone;
    endtask

    // memory and bus traffic seen during one step
    task automatic checkTraffic(input int base, input logic isMiss);
        checkValue("memRead count", memReads, isMiss ? 1 : 0);
        checkValue("memWrite count", memWrites, golden[base+6]);
        if (golden[base+6] != 0) begin
            checkValue("write-back memAddr", wbAddrSeen, golden[base+7]);
            if (isMiss) checkValue("write-back before fill", writeFirst, 1);
        end
        checkValue("busMsgOut", busSeen, golden[base+5]);
        if (golden[base+5] != 0) checkValue("busAddrOut", busAddrSeen, golden[base+2]);
    endtask

    task automatic runCpuStep(input int base);
        int   waitCycles;
        logic isMiss;
        waitCycles = 0;
        isMiss = (golden[base+5] == busReadMiss) || (golden[base+5] == busWriteMiss);
        cpuOp        <= cpuOpType'(golden[base+1][1:0]);
        cpuAddr      <= golden[base+2][7:0];
        cpuWriteData <= golden[base+3];
        do begin
            @(negedge clk);
            waitCycles++;
        end while (!cpuDone);
        if (cpuOp == cpuRead) checkValue("cpuReadData", cpuReadData, golden[base+4]);
        cpuOp <= cpuIdle;  // drop request while cpuDone is up
        if (golden[base+5] == busNone) begin
            checkValue("cpuDone latency", waitCycles, 1);
        end else if (golden[base+5] == busInvalidate) begin
            checkValue("cpuDone latency", waitCycles, 3);  // start, broadcast, finished
        end
        checkTraffic(base, isMiss);
    endtask

    task automatic runSnoopStep(input int base);
        busMsgIn  <= busMsgType'(golden[base+1][1:0]);
        busAddrIn <= golden[base+2][7:0];
        repeat (2) @(negedge clk);  // a write-back has reached memOp by now
        busMsgIn <= busNone;
        while (memOp != memIdle) @(negedge clk);
        repeat (2) @(negedge clk);  // finished, then state update
        checkTraffic(base, 1'b0);
    endtask

    // memory model, 1 to 4 cycles per request
    always @(negedge clk) begin
        if (reset || memDone) begin
            memDone <= 1'b0;
            memWait = 0;
        end else if (memOp != memIdle) begin
            if (memWait == 0) memWait = int'($urandom % 4) + 1;
            memWait = memWait - 1;
            if (memWait == 0) begin
                memDone <= 1'b1;
                if (memOp == memWrite) begin
                    memory[memAddr] = memWriteData;
                    memWrites++;
                    wbAddrSeen = memAddr;
                    writeFirst = (memReads == 0);
                end else begin
                    memReadData <= memory[memAddr];
                    memReads++;
                end
            end
        end
    end

    always @(negedge clk) begin
        if (busMsgOut != busNone && busSeen == busNone) begin
            busSeen     = busMsgOut;  // first broadcast of the step
            busAddrSeen = busAddrOut;
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("timeout: DUT gave no response within %0d cycles", cycleLimit);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        int s;
        void'($urandom(32'h4258));
        reset        = 1'b1;
        cpuOp        = cpuIdle;
        cpuAddr      = '0;
        cpuWriteData = '0;
        memReadData  = '0;
        memDone      = 1'b0;
        busMsgIn     = busNone;
        busAddrIn    = '0;
        memWait      = 0;
        clearStepRecord();
        for (s = 0; s < 256; s++) memory[s] = memSalt ^ s;
        $readmemh("tests/msiCacheGolden.txt", golden);
        stepCount = 0;
        while (stepCount < maxSteps && !$isunknown(golden[stepFields*stepCount])
               && golden[stepFields*stepCount] != 32'hF) stepCount++;
        cycleLimit = 40 * (stepCount + 1);  // one extra step's worth for reset
        if (stepCount == 0) begin
            errorCount++;
            $display("golden file is missing or holds no steps");
        end
        repeat (8) @(negedge clk);
        reset <= 1'b0;
        for (s = 0; s < stepCount; s++) begin
            @(negedge clk);
            clearStepRecord();
            if (golden[stepFields*s] == 0) runCpuStep(stepFields*s);
            else runSnoopStep(stepFields*s);
        end
        repeat (2) @(negedge clk);
        $display("closing: %0d checks, %0d value errors, %0d assertion errors",
                 checkCount, errorCount, dut.props.assertFails);
        if (errorCount == 0 && dut.props.assertFails == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
source/cacheTypesPkg.sv
source/coherencePkg.sv
source/lineStore.sv
source/missHandler.sv
source/coherenceController.sv
source/msiCacheTop.sv
tests/msiCacheProperties.sv
tests/msiCacheTb.sv

// File: tests/msiCacheGolden.txt
// kind (0 cpu, 1 snoop, F end), op or bus message, address, write data,
// expected read data, expected busMsgOut, write-back flag, write-back address
0 1 10 00000000 A5C30F10 1 0 00
0 1 10 00000000 A5C30F10 0 0 00
0 2 20 11112222 00000000 2 0 00
0 1 20 00000000 11112222 0 0 00
0 1 30 00000000 A5C30F30 1 1 20
0 1 20 00000000 11112222 1 0 00
0 2 20 33334444 00000000 3 0 00
0 1 20 00000000 33334444 0 0 00
1 1 20 00000000 00000000 0 1 20
0 1 20 00000000 33334444 0 0 00
1 3 20 00000000 00000000 0 0 00
0 1 20 00000000 33334444 1 0 00
0 2 40 55556666 00000000 2 0 00
1 2 40 00000000 00000000 0 1 40
0 1 40 00000000 55556666 1 0 00
1 1 50 00000000 00000000 0 0 00
0 2 40 77778888 00000000 3 0 00
0 2 60 9999AAAA 00000000 2 1 40
0 1 40 00000000 77778888 1 1 60
1 2 40 00000000 00000000 0 0 00
0 2 70 0BADF00D 00000000 2 0 00
0 2 70 12345678 00000000 0 0 00
0 1 70 00000000 12345678 0 0 00
0 1 60 00000000 9999AAAA 1 1 70
F 0 00 00000000 00000000 0 0 00
